// ==== compareStage.sv ====
// One registered stage of the Batcher odd-even merge network.
// mergeSpan is the sorted block size being merged, compareStep the
// distance between compared lanes. Latency is one clock.

`timescale 1ns/100ps

module compareStage
    import pixelPkg::*, sortNetPkg::*;
#(
    parameter int mergeSpan   = 1,
    parameter int compareStep = 1
) (
    input  logic      clk,
    input  logic      reset,
    input  sortStageT stageIn,
    output sortStageT stageOut
);

    localparam int laneCount = $bits(laneArrayT) / $bits(pixelT);

    // true when lane is the lower lane of a compared pair
    function automatic bit isLowLane(int lane);
        int firstLane;
        firstLane = (compareStep == mergeSpan) ? 0 : compareStep;
        if (lane < firstLane || lane + compareStep >= laneCount) begin
            return 1'b0;
        end
        // first compareStep lanes of each 2*compareStep group
        if (((lane - firstLane) % (2 * compareStep)) >= compareStep) begin
            return 1'b0;
        end
        // both lanes inside the same double-span block
        return (lane / (2 * mergeSpan)) == ((lane + compareStep) / (2 * mergeSpan));
    endfunction

    laneArrayT nextLanes;

    //----------------------------------------------------------------------
    // compare-exchange
    //----------------------------------------------------------------------
    for (genvar lane = 0; lane < laneCount; lane++) begin : gLane
        if (isLowLane(lane)) begin : gLow
            pixelT ownPixel;
            pixelT peerPixel;
            assign ownPixel  = stageIn.lanes[lane];
            assign peerPixel = stageIn.lanes[lane + compareStep];
            // smaller value stays in the lower lane
            assign nextLanes[lane] = (ownPixel > peerPixel) ? peerPixel : ownPixel;
        end else if (lane >= compareStep && isLowLane(lane - compareStep)) begin : gHigh
            pixelT ownPixel;
            pixelT peerPixel;
            assign ownPixel  = stageIn.lanes[lane];
            assign peerPixel = stageIn.lanes[lane - compareStep];
            assign nextLanes[lane] = (ownPixel > peerPixel) ? ownPixel : peerPixel;
        end else begin : gPass
            assign nextLanes[lane] = stageIn.lanes[lane];
        end
    end

    //----------------------------------------------------------------------
    // stage register
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        stageOut.lanes <= nextLanes;
        if (reset) begin
            stageOut.valid <= 1'b0;
        end else begin
            stageOut.valid <= stageIn.valid;
        end
    end

endmodule

// ==== medianFilterTop.sv ====
// Top level of the 3x3 median filter. Takes one window per clock and
// reports its minimum, median and maximum NET_STAGES clocks later.

`timescale 1ns/100ps

`include "medianFilter_defines.svh"

module medianFilterTop
    import pixelPkg::*, sortNetPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        windowValid,
    input  windowWordT  window,
    output filterStatsT stats
);

    localparam int medianLane = `KERNEL_SIZE / 2;
    localparam int maxLane    = `KERNEL_SIZE - 1;

    sortStageT sorted;

    //----------------------------------------------------------------------
    // sorting network
    //----------------------------------------------------------------------
    sortNetwork uSortNetwork (
        .clk         (clk),
        .reset       (reset),
        .windowValid (windowValid),
        .window      (window),
        .sorted      (sorted)
    );

    //----------------------------------------------------------------------
    // order statistics
    //----------------------------------------------------------------------
    // padding lanes sit above maxLane, so only real pixels are picked
    assign stats.valid   = sorted.valid;
    assign stats.minimum = sorted.lanes[0];
    assign stats.median  = sorted.lanes[medianLane];
    assign stats.maximum = sorted.lanes[maxLane];

endmodule

// ==== medianFilter_defines.svh ====
// Sizing macros for the 3x3 median filter kernel.
// Included by the packages, the sorting network, the top and the testbench.

`ifndef MEDIAN_FILTER_DEFINES_SVH
`define MEDIAN_FILTER_DEFINES_SVH

// bits per pixel
`define PIXEL_WIDTH 8

// pixels per window side
`define WINDOW_DIM 3

// pixels per window
`define KERNEL_SIZE 9

// next power of two above the kernel size
`define NETWORK_SIZE 16

// registered stages for 16 lanes: 1+2+3+4
`define NET_STAGES 10

`endif

// ==== pixelPkg.sv ====
// Image-side types: the pixel, the window word and the filter result.
// Imported by the top, the sorting network and the testbench.

`include "medianFilter_defines.svh"

package pixelPkg;

    typedef logic [`PIXEL_WIDTH-1:0] pixelT;

    //----------------------------------------------------------------------
    // window word
    //----------------------------------------------------------------------
    // grid[row][col], row 0 in the lowest bits, col 0 lowest in a row.
    // flat[row*WINDOW_DIM + col] names the same pixel.
    typedef union packed {
        pixelT [`WINDOW_DIM-1:0][`WINDOW_DIM-1:0] grid;
        pixelT [`KERNEL_SIZE-1:0]                 flat;
    } windowWordT;

    //----------------------------------------------------------------------
    // filter result
    //----------------------------------------------------------------------
    // valid qualifies the three order statistics
    typedef struct packed {
        logic  valid;
        pixelT minimum;
        pixelT median;
        pixelT maximum;
    } filterStatsT;

endpackage

// ==== run.sh ====
#!/bin/sh
# Compile the median filter testbench with Verilator and run it.
# Exits nonzero unless the pass message appears in the output.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f src.f --top-module tbMedianFilter \
    -o simMedianFilter &&
simOut="$(./obj_dir/simMedianFilter)" ;
echo "$simOut" &&
echo "$simOut" | grep -q "TESTBENCH PASSED" &&
echo "simulation passed" && exit 0 ||
{ echo "simulation failed"; exit 1; }

// ==== sortNetPkg.sv ====
// Sorting-network types: the lane array and the stage word passed
// between compare stages. Imported by the network modules and the top.

`include "medianFilter_defines.svh"

package sortNetPkg;

    import pixelPkg::*;

    //----------------------------------------------------------------------
    // lanes
    //----------------------------------------------------------------------
    // lane 0 in the lowest bits, ascending after the last stage
    typedef pixelT [`NETWORK_SIZE-1:0] laneArrayT;

    //----------------------------------------------------------------------
    // stage word
    //----------------------------------------------------------------------
    // one window in flight with its valid bit
    typedef struct packed {
        logic      valid;
        laneArrayT lanes;
    } sortStageT;

endpackage

// ==== sortNetwork.sv ====
// Pads the window to a power-of-two lane count and sorts it through a
// chain of compare stages. Sorted lanes come out NET_STAGES clocks later.

`timescale 1ns/100ps

`include "medianFilter_defines.svh"

module sortNetwork
    import pixelPkg::*, sortNetPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       windowValid,
    input  windowWordT window,
    output sortStageT  sorted
);

    localparam int spanLevels = $clog2(`NETWORK_SIZE);

    // stageBus[0] is the padded input, the last entry the sorted result
    sortStageT stageBus [`NET_STAGES+1];

    //----------------------------------------------------------------------
    // input padding
    //----------------------------------------------------------------------
    assign stageBus[0].valid = windowValid;

    for (genvar lane = 0; lane < `NETWORK_SIZE; lane++) begin : gPad
        if (lane < `KERNEL_SIZE) begin : gPixel
            assign stageBus[0].lanes[lane] = window.flat[lane];
        end else begin : gFill
            // all-ones sorts above every real pixel
            assign stageBus[0].lanes[lane] = '1;
        end
    end

    //----------------------------------------------------------------------
    // merge stages
    //----------------------------------------------------------------------
    // span 1,2,4,8; within a span the step halves from span down to 1
    for (genvar level = 0; level < spanLevels; level++) begin : gSpan
        for (genvar sub = 0; sub <= level; sub++) begin : gStep
            localparam int stageIdx = (level * (level + 1)) / 2 + sub;

            compareStage #(
                .mergeSpan   (1 << level),
                .compareStep ((1 << level) >> sub)
            ) uCompareStage (
                .clk      (clk),
                .reset    (reset),
                .stageIn  (stageBus[stageIdx]),
                .stageOut (stageBus[stageIdx + 1])
            );
        end
    end

    assign sorted = stageBus[`NET_STAGES];

endmodule

// ==== src.f ====
+incdir+.
pixelPkg.sv
sortNetPkg.sv
compareStage.sv
sortNetwork.sv
medianFilterTop.sv
tbMedianFilter.sv

// ==== tbMedianFilter.sv ====
// Testbench for the 3x3 median filter top level.
// Drives random, gapped and corner windows and checks the order statistics
// against a sorted reference model held in a queue.

`timescale 1ns/100ps

`include "medianFilter_defines.svh"

module tbMedianFilter
    import pixelPkg::*;
();

    localparam int clkPeriod   = 20;
    localparam int resetCycles = 8;
    localparam int leadIdle    = 14;
    localparam int backToBack  = 200;
    localparam int mixedCycles = 150;
    localparam int cornerCount = 4;
    localparam int tailCycles  = `NET_STAGES + 2;
    localparam int stimCycles  = resetCycles + leadIdle + backToBack + mixedCycles
                                 + cornerCount + tailCycles;

    // one accepted window and the edge it was taken on
    typedef struct packed {
        logic [31:0] acceptEdge;
        filterStatsT expected;
    } expectEntryT;

    logic        clk;
    logic        reset;
    logic        windowValid;
    windowWordT  window;
    filterStatsT stats;

    int          seed = 32'hb52038a5;
    int unsigned edgeCount = 0;
    int          mismatchCount = 0;
    int          otherCount = 0;
    expectEntryT expectQueue [$];
    expectEntryT current;
    logic        expValid = 1'b0;

    medianFilterTop i_dut (
        .clk         (clk),
        .reset       (reset),
        .windowValid (windowValid),
        .window      (window),
        .stats       (stats)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    always @(posedge clk) begin
        edgeCount <= edgeCount + 1;
    end

    //----------------------------------------------------------------------
    // reference model
    //----------------------------------------------------------------------
    // insertion sort of the nine pixels, read through the grid view
    function automatic filterStatsT expectedStats(windowWordT w);
        pixelT       pixels [`KERNEL_SIZE];
        pixelT       key;
        int          j;
        filterStatsT result;
        for (int r = 0; r < `WINDOW_DIM; r++) begin
            for (int c = 0; c < `WINDOW_DIM; c++) begin
                pixels[r * `WINDOW_DIM + c] = w.grid[r][c];
            end
        end
        for (int i = 1; i < `KERNEL_SIZE; i++) begin
            key = pixels[i];
            j = i - 1;
            while (j >= 0 && pixels[j] > key) begin
                pixels[j + 1] = pixels[j];
                j--;
            end
            pixels[j + 1] = key;
        end
        result.valid   = 1'b1;
        result.minimum = pixels[0];
        result.median  = pixels[`KERNEL_SIZE / 2];
        result.maximum = pixels[`KERNEL_SIZE - 1];
        return result;
    endfunction

    task automatic makeRandomWindow(output windowWordT w);
        for (int r = 0; r < `WINDOW_DIM; r++) begin
            for (int c = 0; c < `WINDOW_DIM; c++) begin
                w.grid[r][c] = pixelT'($random(seed));
            end
        end
    endtask

    // drives one input cycle and records the window if it is accepted
    task automatic driveCycle(input logic valid, input windowWordT w);
        expectEntryT entry;
        @(negedge clk);
        windowValid = valid;
        window = w;
        if (valid) begin
            entry.acceptEdge = edgeCount + 1;
            entry.expected = expectedStats(w);
            expectQueue.push_back(entry);
        end
    endtask

    //----------------------------------------------------------------------
    // checks at the falling edge where outputs are stable
    //----------------------------------------------------------------------
    always @(negedge clk) begin
        expValid = 1'b0;
        // last stage register loads NET_STAGES-1 edges after the accepting edge
        if (expectQueue.size() != 0 &&
            expectQueue[0].acceptEdge + `NET_STAGES - 1 == edgeCount) begin
            current = expectQueue.pop_front();
            expValid = 1'b1;
        end
        if (edgeCount != 0) begin
            assert (expValid || !stats.valid) else begin
                otherCount++;
                $display("Error at %0t: output valid without a window accepted %0d cycles before",
                         $time, `NET_STAGES);
            end
            assert (!expValid || stats.valid) else begin
                otherCount++;
                $display("Error at %0t: window accepted on edge %0d never reached the output",
                         $time, current.acceptEdge);
            end
            if (expValid && stats.valid) begin
                assert (stats.minimum == current.expected.minimum) else begin
                    mismatchCount++;
                    $display("Mismatch at %0t: minimum is %0d, expected %0d",
                             $time, stats.minimum, current.expected.minimum);
                end
                assert (stats.median == current.expected.median) else begin
                    mismatchCount++;
                    $display("Mismatch at %0t: median is %0d, expected %0d",
                             $time, stats.median, current.expected.median);
                end
                assert (stats.maximum == current.expected.maximum) else begin
                    mismatchCount++;
                    $display("Mismatch at %0t: maximum is %0d, expected %0d",
                             $time, stats.maximum, current.expected.maximum);
                end
            end
        end
    end

    //----------------------------------------------------------------------
    // stimulus
    //----------------------------------------------------------------------
    initial begin
        windowWordT w;
        int         gapDraw;
        reset = 1'b1;
        windowValid = 1'b0;
        window = '0;
        repeat (resetCycles) @(negedge clk);
        reset = 1'b0;

        // quiet output before the first window
        repeat (leadIdle) driveCycle(1'b0, '0);

        for (int n = 0; n < backToBack; n++) begin
            makeRandomWindow(w);
            driveCycle(1'b1, w);
        end

        // roughly one idle cycle in four
        for (int n = 0; n < mixedCycles; n++) begin
            makeRandomWindow(w);
            gapDraw = $random(seed);
            driveCycle(gapDraw[1:0] != 2'b00, w);
        end

        // corner windows
        w = '0;
        for (int r = 0; r < `WINDOW_DIM; r++) begin
            for (int c = 0; c < `WINDOW_DIM; c++) begin
                w.grid[r][c] = 8'h5a;
            end
        end
        driveCycle(1'b1, w);
        w = '1;
        driveCycle(1'b1, w);
        w.grid[1][2] = '0;
        driveCycle(1'b1, w);
        for (int r = 0; r < `WINDOW_DIM; r++) begin
            for (int c = 0; c < `WINDOW_DIM; c++) begin
                w.grid[r][c] = pixelT'(200 - 20 * (r * `WINDOW_DIM + c));
            end
        end
        driveCycle(1'b1, w);

        driveCycle(1'b0, '0);
        while (expectQueue.size() != 0) begin
            @(negedge clk);
        end
        repeat (tailCycles) @(negedge clk);

        $display("errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
        if (mismatchCount == 0 && otherCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((stimCycles + `NET_STAGES + 20) * clkPeriod);
        $display("Error: timeout, %0d expected results still pending", expectQueue.size());
        $display("errors: %0d mismatches, %0d other failures", mismatchCount, otherCount + 1);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
